// File: common/serial_pkg.sv
package serial_pkg;

	// serial word length and bit counter
	localparam int BITS = 8;
	localparam int BIT_CNT_W = $clog2(BITS);
	// index of the last bit in a word
	localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(BITS - 1);

	// in_clk cycles per serial half period, small for simulation
	localparam int SERIAL_CLK_DIV = 4;

	// idle levels of the pins
	localparam logic SERIAL_CLK_INACTIVE = 1'b1;
	localparam logic SERIAL_DATA_INACTIVE = 1'b1;

	// 1: bit 0 goes out first
	localparam bit LOWBIT_FIRST = 1'b1;

	// bus widths
	localparam int WB_DW = 32;
	localparam int WB_AW = 4;

	// word addresses
	localparam logic [WB_AW-1:0] REG_CTRL = 4'd0;
	localparam logic [WB_AW-1:0] REG_TX = 4'd1;
	localparam logic [WB_AW-1:0] REG_RX = 4'd2;

	// control register bits
	localparam int CTRL_START = 0;
	localparam int CTRL_BUSY = 1;
	localparam int CTRL_DONE = 2;

	// master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic ack;
		logic [WB_DW-1:0] dat;
	} wb_rsp_t;

	// register block to shift controller
	typedef struct packed {
		logic start;
		logic [BITS-1:0] data;
	} shift_cmd_t;

	// shift controller to register block
	typedef struct packed {
		logic busy;
		logic done;
		logic [BITS-1:0] data;
	} shift_stat_t;

	// link pins driven by us
	typedef struct packed {
		logic sclk;
		logic sdo;
	} ser_out_t;

endpackage

// File: logic/clkgen.sv
`timescale 1ns/1ns

module clkgen
	import serial_pkg::*;
#(
	parameter int DIV = 4
) (
	input logic in_clk,
	input logic in_rst,
	input logic run,
	output logic tick_fall,
	output logic tick_rise,
	output logic level
);

	// counter wide enough for DIV - 1
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic expire;

	// end of a half period
	assign expire = run && (cnt == '0);
	// edge the toggle is about to make
	assign tick_fall = expire && level;
	assign tick_rise = expire && !level;

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			cnt <= CNT_W'(DIV - 1);
			level <= SERIAL_CLK_INACTIVE;
		end else if (!run) begin
			// idle: restart count on next run
			cnt <= CNT_W'(DIV - 1);
			level <= SERIAL_CLK_INACTIVE;
		end else if (expire) begin
			cnt <= CNT_W'(DIV - 1);
			level <= ~level;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

// File: serial/serial_shift.sv
`timescale 1ns/1ns

module serial_shift
	import serial_pkg::*;
(
	input logic in_clk,
	input logic in_rst,
	input shift_cmd_t cmd,
	output shift_stat_t stat,
	output ser_out_t pins,
	input logic sdi
);

	// shifter states
	typedef enum logic {
		st_ready,
		st_transmit
	} state_t;

	state_t state;

	// bit counter and its mapping to a word index
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [BIT_CNT_W-1:0] bit_idx;

	// word being sent and word being received
	logic [BITS-1:0] tx_word;
	logic [BITS-1:0] rx_word;

	// registered data output
	logic sdo_q;

	// end of word pulse
	logic done_q;

	// slow clock ticks
	logic busy;
	logic tick_fall;
	logic tick_rise;
	logic sclk_level;

	assign busy = (state == st_transmit);

	// bit order is fixed at build time
	assign bit_idx = LOWBIT_FIRST ? bit_cnt : (LAST_BIT - bit_cnt);

	// half period ticks, counted only while shifting
	clkgen #(
		.DIV(SERIAL_CLK_DIV)
	) i_clkgen (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.run(busy),
		.tick_fall(tick_fall),
		.tick_rise(tick_rise),
		.level(sclk_level)
	);

	// state machine and bit counter
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= st_ready;
			bit_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				st_ready: begin
					// new word from the register block
					if (cmd.start) begin
						state <= st_transmit;
						bit_cnt <= '0;
					end
				end
				st_transmit: begin
					// one bit per rising edge
					if (tick_rise) begin
						if (bit_cnt == LAST_BIT) begin
							state <= st_ready;
							done_q <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: begin
					state <= st_ready;
				end
			endcase
		end
	end

	// data out changes at the falling sclk edge
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			sdo_q <= SERIAL_DATA_INACTIVE;
		end else if (tick_fall) begin
			sdo_q <= tx_word[bit_idx];
		end else if (done_q) begin
			// last bit already sampled, back to idle
			sdo_q <= SERIAL_DATA_INACTIVE;
		end
	end

	// word buffers
	always_ff @(posedge in_clk) begin
		// capture transmit word at start
		if ((state == st_ready) && cmd.start) begin
			tx_word <= cmd.data;
		end
		// sample input at the rising sclk edge
		if (tick_rise) begin
			rx_word[bit_idx] <= sdi;
		end
	end

	// status towards the register block
	always_comb begin
		stat.busy = busy;
		stat.done = done_q;
		stat.data = rx_word;
	end

	// pins, clock only runs while shifting
	always_comb begin
		pins.sclk = busy ? sclk_level : SERIAL_CLK_INACTIVE;
		pins.sdo = sdo_q;
	end

endmodule

// File: logic/wb_serial_regs.sv
`timescale 1ns/1ns

module wb_serial_regs
	import serial_pkg::*;
(
	input logic in_clk,
	input logic in_rst,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output shift_cmd_t cmd,
	input shift_stat_t stat,
	output logic irq
);

	// bus handshake
	logic req_hit;
	logic ack_q;
	logic [WB_DW-1:0] rd_dat;
	logic [WB_DW-1:0] dat_q;

	// decoded accesses
	logic wr_ctrl;
	logic wr_tx;
	logic rd_ctrl;
	logic start_req;

	// software visible state
	logic [BITS-1:0] tx_reg;
	logic [BITS-1:0] rx_reg;
	logic done_bit;
	logic start_q;

	// request still present in the ack cycle is not taken again
	assign req_hit = wb_req.cyc && wb_req.stb && !ack_q;

	assign wr_ctrl = req_hit && wb_req.we && (wb_req.adr == REG_CTRL);
	assign wr_tx = req_hit && wb_req.we && (wb_req.adr == REG_TX);
	assign rd_ctrl = req_hit && !wb_req.we && (wb_req.adr == REG_CTRL);

	// start only when the shifter is idle
	assign start_req = wr_ctrl && wb_req.dat[CTRL_START] && !stat.busy;

	// read mux, unmapped addresses read zero
	always_comb begin
		rd_dat = '0;
		case (wb_req.adr)
			REG_CTRL: begin
				rd_dat[CTRL_BUSY] = stat.busy;
				rd_dat[CTRL_DONE] = done_bit;
			end
			REG_TX: begin
				rd_dat = WB_DW'(tx_reg);
			end
			REG_RX: begin
				rd_dat = WB_DW'(rx_reg);
			end
			default: begin
				rd_dat = '0;
			end
		endcase
	end

	// ack and start, one cycle each
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			ack_q <= 1'b0;
			start_q <= 1'b0;
		end else begin
			ack_q <= req_hit;
			start_q <= start_req;
		end
	end

	// read data lines up with ack
	always_ff @(posedge in_clk) begin
		if (req_hit) begin
			dat_q <= rd_dat;
		end
	end

	// registers
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			tx_reg <= '0;
			rx_reg <= '0;
			done_bit <= 1'b0;
		end else begin
			if (wr_tx) begin
				tx_reg <= wb_req.dat[BITS-1:0];
			end
			// received word lands one cycle after done
			if (stat.done) begin
				rx_reg <= stat.data;
			end
			// sticky done, cleared by control read or new word
			if (stat.done) begin
				done_bit <= 1'b1;
			end else if (rd_ctrl || start_q) begin
				done_bit <= 1'b0;
			end
		end
	end

	always_comb begin
		wb_rsp.ack = ack_q;
		wb_rsp.dat = dat_q;
	end

	always_comb begin
		cmd.start = start_q;
		cmd.data = tx_reg;
	end

	// level interrupt
	assign irq = done_bit;

endmodule

// File: logic/serial_top.sv
`timescale 1ns/1ns

module serial_top
	import serial_pkg::*;
(
	input logic in_clk,
	input logic in_rst,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output ser_out_t pins,
	input logic sdi,
	output logic irq
);

	// register block to shifter
	shift_cmd_t cmd;
	// shifter back to register block
	shift_stat_t stat;

	// bus side
	wb_serial_regs i_wb_serial_regs (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.cmd(cmd),
		.stat(stat),
		.irq(irq)
	);

	// link side
	serial_shift i_serial_shift (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.cmd(cmd),
		.stat(stat),
		.pins(pins),
		.sdi(sdi)
	);

endmodule

// File: bench/serial_tb.sv
`timescale 1ns/1ns

module serial_tb
	import serial_pkg::*;
();

	localparam int NUM_ROWS = 8;
	localparam int NUM_FIXED = 4;
	localparam int ACK_LIMIT = 8;
	localparam int POLL_LIMIT = 100;
	// about 100 cycles per word plus reset and slack
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 100 + 1000;
	localparam ser_out_t IDLE_PINS = {SERIAL_CLK_INACTIVE, SERIAL_DATA_INACTIVE};
	localparam logic [WB_DW-1:0] CTRL_GO = WB_DW'(1) << CTRL_START;

	// one word on the link and what should come back
	typedef struct packed {
		logic [BITS-1:0] tx;
		logic [BITS-1:0] reply;
		logic [BITS-1:0] exp_rx;
		logic restart;
	} row_t;

	logic in_clk;
	logic in_rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	ser_out_t pins;
	logic sdi;
	logic irq;

	row_t rows [NUM_ROWS];

	// device model state
	logic [BITS-1:0] reply_word;
	logic [BITS-1:0] cap_word;
	int fall_cnt;
	int rise_cnt;

	serial_top i_serial_top (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.pins(pins),
		.sdi(sdi),
		.irq(irq)
	);

	always #10 in_clk = ~in_clk;

	// word bit carried by the n-th clock period
	function automatic int order_index(input int n);
		return LOWBIT_FIRST ? n : BITS - 1 - n;
	endfunction

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_wb_dat(input wb_rsp_t got, input logic [WB_DW-1:0] exp,
			input string name);
		if (got.dat !== exp) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got.dat, exp);
			abort_run();
		end
	endtask

	task automatic check_pins(input ser_out_t got, input ser_out_t exp, input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got sclk %b sdo %b expected sclk %b sdo %b",
				$time, name, got.sclk, got.sdo, exp.sclk, exp.sdo);
			abort_run();
		end
	endtask

	task automatic check_word(input logic [BITS-1:0] got, input logic [BITS-1:0] exp,
			input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// called 2 ns after an edge, returns 2 ns after the ack edge
	task automatic wait_ack();
		int waited;
		waited = 0;
		@(posedge in_clk);
		#2;
		while (wb_rsp.ack !== 1'b1 && waited < ACK_LIMIT) begin
			waited++;
			@(posedge in_clk);
			#2;
		end
		if (wb_rsp.ack !== 1'b1) begin
			$display("no ack from the bus slave within %0d cycles at %0t ns", ACK_LIMIT, $time);
			abort_run();
		end
	endtask

	task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wait_ack();
		wb_req = '0;
	endtask

	task automatic wb_read(input logic [WB_AW-1:0] adr, output wb_rsp_t rsp);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b0;
		wb_req.adr = adr;
		wb_req.dat = '0;
		wait_ack();
		// read data is valid in the ack cycle
		rsp = wb_rsp;
		wb_req = '0;
	endtask

	// link must rest between words
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge in_clk);
			#2;
			check_pins(pins, IDLE_PINS, "pins between words");
		end
	endtask

	task automatic run_row(input row_t row);
		wb_rsp_t rsp;
		logic irq_before;
		int polls;
		// arm the device model
		reply_word = row.reply;
		cap_word = '0;
		fall_cnt = 0;
		rise_cnt = 0;
		wb_write(REG_TX, WB_DW'(row.tx));
		wb_write(REG_CTRL, CTRL_GO);
		if (row.restart) begin
			// second start while shifting, must be dropped
			wb_read(REG_CTRL, rsp);
			check_wb_dat(rsp, WB_DW'(1) << CTRL_BUSY, "ctrl while busy");
			wb_write(REG_CTRL, CTRL_GO);
		end
		// irq sampled just before each poll
		polls = 0;
		irq_before = irq;
		wb_read(REG_CTRL, rsp);
		while (rsp.dat[CTRL_DONE] !== 1'b1 && polls < POLL_LIMIT) begin
			polls++;
			irq_before = irq;
			wb_read(REG_CTRL, rsp);
		end
		if (rsp.dat[CTRL_DONE] !== 1'b1) begin
			$display("done flag never set after %0d polls at %0t ns", POLL_LIMIT, $time);
			abort_run();
		end
		check_wb_dat(rsp, WB_DW'(1) << CTRL_DONE, "ctrl at done");
		check_flag(irq_before, 1'b1, "irq at done");
		check_word(cap_word, row.tx, "sdo word");
		if (rise_cnt != BITS || fall_cnt != BITS) begin
			$display("device model saw %0d rising and %0d falling sclk edges instead of %0d",
				rise_cnt, fall_cnt, BITS);
			abort_run();
		end
		wb_read(REG_RX, rsp);
		check_wb_dat(rsp, WB_DW'(row.exp_rx), "rx register");
		// done was consumed by the poll
		wb_read(REG_CTRL, rsp);
		check_wb_dat(rsp, '0, "ctrl after clear");
		check_flag(irq, 1'b0, "irq after clear");
	endtask

	// device model, answers with the inverted reply word
	always begin
		@(negedge pins.sclk);
		#2;
		if (fall_cnt < BITS) begin
			sdi = ~reply_word[order_index(fall_cnt)];
		end
		fall_cnt++;
	end

	// device model, records sdo at the rising edge
	always begin
		@(posedge pins.sclk);
		#1;
		if (rise_cnt < BITS) begin
			cap_word[order_index(rise_cnt)] = pins.sdo;
		end
		rise_cnt++;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge in_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		int unsigned rnd;
		wb_rsp_t rsp;
		in_clk = 1'b0;
		in_rst = 1'b1;
		wb_req = '0;
		sdi = 1'b1;
		reply_word = '0;
		cap_word = '0;
		fall_cnt = 0;
		rise_cnt = 0;
		rnd = $urandom(32'h1c22);
		// tx, reply, expected rx, start again while busy
		rows[0] = {8'h00, 8'hff, 8'h00, 1'b0};
		rows[1] = {8'hff, 8'h00, 8'hff, 1'b0};
		rows[2] = {8'ha5, 8'h3c, 8'hc3, 1'b1};
		rows[3] = {8'h81, 8'h7e, 8'h81, 1'b0};
		for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
			rnd = $urandom;
			rows[i].tx = rnd[BITS-1:0];
			rows[i].reply = rnd[2*BITS-1:BITS];
			rows[i].exp_rx = ~rnd[2*BITS-1:BITS];
			rows[i].restart = rnd[31];
		end
		repeat (5) @(posedge in_clk);
		#2;
		in_rst = 1'b0;
		// state straight after reset
		check_pins(pins, IDLE_PINS, "pins after reset");
		check_flag(irq, 1'b0, "irq after reset");
		wb_read(REG_CTRL, rsp);
		check_wb_dat(rsp, '0, "ctrl after reset");
		wb_read(REG_TX, rsp);
		check_wb_dat(rsp, '0, "tx after reset");
		wb_read(REG_RX, rsp);
		check_wb_dat(rsp, '0, "rx after reset");
		for (int i = 0; i < NUM_ROWS; i++) begin
			idle_cycles(3);
			run_row(rows[i]);
		end
		idle_cycles(3);
		$display("test passed");
		$finish;
	end

endmodule

// File: serial_bridge.f
common/serial_pkg.sv
logic/clkgen.sv
serial/serial_shift.sv
logic/wb_serial_regs.sv
logic/serial_top.sv
bench/serial_tb.sv

// File: Bender.yml
package:
  name: serial_bridge

sources:
  # shared package first
  - common/serial_pkg.sv
  # design
  - logic/clkgen.sv
  - serial/serial_shift.sv
  - logic/wb_serial_regs.sv
  - logic/serial_top.sv
  # testbench
  - target: test
    files:
      - bench/serial_tb.sv
